// File: phy_io_macros.svh
/*
 Shared sizing for the PHY I/O pad model. Derived widths assume full-rate
 AFI (two slots per cycle) and a power-of-two read FIFO depth.
*/
`ifndef PHY_IO_MACROS_SVH
`define PHY_IO_MACROS_SVH

// DQS group geometry
`define PHY_NUM_GROUPS 2
`define PHY_GROUP_DQ_WIDTH 8
`define PHY_GROUP_DM_WIDTH 1
`define PHY_RATE_SLOTS 2

// AFI bus widths, ordered slot-major then group
`define PHY_AFI_DQS_WIDTH (`PHY_RATE_SLOTS * `PHY_NUM_GROUPS)
`define PHY_AFI_DATA_WIDTH (`PHY_AFI_DQS_WIDTH * `PHY_GROUP_DQ_WIDTH)
`define PHY_AFI_MASK_WIDTH (`PHY_AFI_DQS_WIDTH * `PHY_GROUP_DM_WIDTH)

// Read side limits
`define PHY_EXTRA_SHIFT 1
`define PHY_RD_LAT_WIDTH 5
`define PHY_RD_LAT_MAX ((1 << `PHY_RD_LAT_WIDTH) - 1)
`define PHY_RD_FIFO_DEPTH 8
`define PHY_RD_PTR_WIDTH 3

`endif

// File: phy_io_pkg.sv
/*
 Bus and lane types for the PHY I/O pad model. AFI buses are slot-major,
 group-minor. Per-group DDR words keep the later slot in the upper bits.
*/
`include "phy_io_macros.svh"

package phy_io_pkg;

	// Full AFI write side buses
	typedef logic [`PHY_AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [`PHY_AFI_MASK_WIDTH-1:0] afi_mask_t;

	// One enable per slot and group, shared by wrdata_en, dqs_en and oct_ena
	typedef logic [`PHY_AFI_DQS_WIDTH-1:0] afi_strobe_t;

	// One group's view across all slots
	typedef logic [`PHY_RATE_SLOTS*`PHY_GROUP_DQ_WIDTH-1:0] group_ddr_dq_t;
	typedef logic [`PHY_RATE_SLOTS*`PHY_GROUP_DM_WIDTH-1:0] group_ddr_dm_t;
	typedef logic [`PHY_RATE_SLOTS-1:0] group_ddr_en_t;

	// Read latency setting, in AFI cycles
	typedef logic [`PHY_RD_LAT_WIDTH-1:0] rd_lat_t;

	// Read FIFO pointer, wraps on its own since the depth is a power of two
	typedef logic [`PHY_RD_PTR_WIDTH-1:0] rd_ptr_t;

endpackage

// File: phy_c2p_reg.sv
/*
 Core-to-periphery register stage. Adds exactly one pll_afi_clk cycle.
 The payload is cleared by the asynchronous reset so that enables
 start inactive.
*/
`timescale 1ns/1ns

module phy_c2p_reg #(
	parameter type payload_t = logic
) (
	input  logic     pll_afi_clk,
	input  logic     reset_n_afi_clk,
	input  payload_t d,
	output payload_t q
);

	// Retimes the core-side bus into the periphery domain of the same clock
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

// File: phy_wr_lane.sv
/*
 Write slicer for one DQS group. Purely combinational. GROUP must be
 below PHY_NUM_GROUPS; the inputs are the registered AFI buses.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module phy_wr_lane
	import phy_io_pkg::*;
#(
	parameter int GROUP = 0
) (
	input  afi_data_t     c2p_dq,
	input  afi_mask_t     c2p_mask,
	input  afi_strobe_t   c2p_wrdata_en,
	input  afi_strobe_t   c2p_dqs_en,
	input  afi_strobe_t   c2p_oct_ena,
	output group_ddr_dq_t lane_dq,
	output group_ddr_dm_t lane_dm,
	output logic [`PHY_RATE_SLOTS*`PHY_GROUP_DQ_WIDTH-1:0] lane_oe,
	output group_ddr_en_t lane_dqs_en,
	output group_ddr_en_t lane_oct_ena
);

	localparam int DQ_W = `PHY_GROUP_DQ_WIDTH;
	localparam int DM_W = `PHY_GROUP_DM_WIDTH;

	// The AFI bus holds all groups of slot 0, then all groups of slot 1.
	// Field index s * PHY_NUM_GROUPS + GROUP is this group's share of slot s
	for (genvar s = 0; s < `PHY_RATE_SLOTS; s++) begin : g_slot
		localparam int FIELD = s * `PHY_NUM_GROUPS + GROUP;

		assign lane_dq[s*DQ_W +: DQ_W] = c2p_dq[FIELD*DQ_W +: DQ_W];
		assign lane_dm[s*DM_W +: DM_W] = c2p_mask[FIELD*DM_W +: DM_W];

		// Output enable drives every DQ pin of the group in this slot
		assign lane_oe[s*DQ_W +: DQ_W] = {DQ_W{c2p_wrdata_en[FIELD]}};

		assign lane_dqs_en[s] = c2p_dqs_en[FIELD];
		assign lane_oct_ena[s] = c2p_oct_ena[FIELD];
	end

endmodule

// File: phy_rd_lat_line.sv
/*
 Read latency line for one DQS group. rd_latency must stay in 1..31;
 a value of 0 has no tap. Changing it while enables are in flight
 moves the tap and can drop or repeat a valid.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module phy_rd_lat_line
	import phy_io_pkg::*;
(
	input  logic    pll_afi_clk,
	input  logic    reset_n_afi_clk,
	input  logic    rd_en_shifted,
	input  rd_lat_t rd_latency,
	output logic    group_valid
);

	// Stage k holds the enable as it was k cycles ago
	logic [`PHY_RD_LAT_MAX:1] lat_stage;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			lat_stage <= '0;
		end else begin
			lat_stage <= {lat_stage[`PHY_RD_LAT_MAX-1:1], rd_en_shifted};
		end
	end

	// Tap selected by the sequencer's latency counter
	assign group_valid = lat_stage[rd_latency];

	// The sequencer must never program a zero latency
	a_lat_nonzero: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		rd_latency != '0
	) else $error("phy_rd_lat_line: rd_latency is 0");

endmodule

// File: phy_rd_fifo.sv
/*
 Read FIFO for one DQS group. No back-pressure: the producer must not
 overfill it and the latency line must not pop it empty. pop_word holds
 the last popped word and is cleared only by reset.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module phy_rd_fifo
	import phy_io_pkg::*;
#(
	parameter type word_t = logic
) (
	input  logic  pll_afi_clk,
	input  logic  reset_n_afi_clk,
	input  logic  rd_fifo_clear,
	input  logic  push,
	input  word_t push_word,
	input  logic  pop,
	output word_t pop_word
);

	word_t mem [`PHY_RD_FIFO_DEPTH];

	rd_ptr_t wr_ptr;
	rd_ptr_t rd_ptr;
	logic [`PHY_RD_PTR_WIDTH:0] count;

	logic full;
	logic empty;

	assign full = (count == `PHY_RD_FIFO_DEPTH);
	assign empty = (count == '0);

	// Storage
	always_ff @(posedge pll_afi_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (rd_fifo_clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Output register, loads on the group valid and holds in between
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			pop_word <= '0;
		end else if (pop) begin
			pop_word <= mem[rd_ptr];
		end
	end

	a_no_overflow: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk || rd_fifo_clear)
		push && full |-> pop
	) else $error("phy_rd_fifo: push while full");

	a_no_underflow: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk || rd_fifo_clear)
		pop |-> !empty
	) else $error("phy_rd_fifo: pop while empty");

endmodule

// File: phy_io_ctrl.sv
/*
 Read-side control for the pad block. Only bit 0 of the AFI read enable
 exists here, since all slots carry the same value at full rate.
 The FIFO clear level is combinational and not affected by reset.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module phy_io_ctrl (
	input  logic                        pll_afi_clk,
	input  logic                        reset_n_afi_clk,
	input  logic                        phy_reset_mem_stable,
	input  logic                        seq_read_fifo_reset,
	input  logic                        afi_rdata_en_full,
	input  logic [`PHY_NUM_GROUPS-1:0]  group_valid,
	output logic                        rd_en_shifted,
	output logic                        rd_fifo_clear,
	output logic [`PHY_RATE_SLOTS-1:0]  afi_rdata_valid
);

	logic [`PHY_EXTRA_SHIFT-1:0] en_shift;
	logic all_valid;

	// Extra read-enable shift ahead of the per-group latency lines
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			en_shift <= '0;
		end else begin
			en_shift[0] <= afi_rdata_en_full;
			for (int i = 1; i < `PHY_EXTRA_SHIFT; i++) begin
				en_shift[i] <= en_shift[i-1];
			end
		end
	end

	assign rd_en_shifted = en_shift[`PHY_EXTRA_SHIFT-1];

	// Either an unstable memory interface or a sequencer request empties the FIFOs
	assign rd_fifo_clear = !phy_reset_mem_stable || seq_read_fifo_reset;

	// Data is only valid once every group has its word ready
	assign all_valid = &group_valid;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {`PHY_RATE_SLOTS{all_valid}};
		end
	end

	// All latency lines share one enable and one setting, so they move together
	a_groups_aligned: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(group_valid == '0) || all_valid
	) else $error("phy_io_ctrl: group valids disagree (%b)", group_valid);

endmodule

// File: phy_io_pads.sv
/*
 Single-clock model of the DDR PHY data pad block. Write buses reach the
 mem_* lanes one cycle after input. Captured read words are pushed by a
 per-group strobe and returned on ddio_phy_dq with afi_rdata_valid.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module phy_io_pads
	import phy_io_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,

	input  logic        phy_reset_mem_stable,
	input  logic        seq_read_fifo_reset,
	input  rd_lat_t     seq_read_latency_counter,
	input  logic        afi_rdata_en_full,

	input  afi_data_t   phy_ddio_dq,
	input  afi_strobe_t phy_ddio_wrdata_en,
	input  afi_mask_t   phy_ddio_wrdata_mask,
	input  afi_strobe_t phy_ddio_dqs_en,
	input  afi_strobe_t phy_ddio_oct_ena,

	input  logic [`PHY_AFI_DATA_WIDTH-1:0] mem_rd_dq,
	input  logic [`PHY_NUM_GROUPS-1:0]     mem_rd_strobe,

	output wire [`PHY_AFI_DATA_WIDTH-1:0]                   mem_wr_dq,
	output wire [`PHY_AFI_MASK_WIDTH-1:0]                   mem_wr_dm,
	output wire [`PHY_AFI_DQS_WIDTH*`PHY_GROUP_DQ_WIDTH-1:0] mem_wr_oe,
	output wire [`PHY_AFI_DQS_WIDTH-1:0]                    mem_dqs_en,
	output wire [`PHY_AFI_DQS_WIDTH-1:0]                    mem_oct_ena,
	output wire [`PHY_AFI_DATA_WIDTH-1:0]                   ddio_phy_dq,
	output wire [`PHY_RATE_SLOTS-1:0]                       afi_rdata_valid
);

	localparam int LANE_DQ_W = $bits(group_ddr_dq_t);
	localparam int LANE_DM_W = $bits(group_ddr_dm_t);
	localparam int LANE_EN_W = $bits(group_ddr_en_t);

	wire afi_data_t   c2p_dq;
	wire afi_mask_t   c2p_mask;
	wire afi_strobe_t c2p_wrdata_en;
	wire afi_strobe_t c2p_dqs_en;
	wire afi_strobe_t c2p_oct_ena;

	wire rd_en_shifted;
	wire rd_fifo_clear;
	wire [`PHY_NUM_GROUPS-1:0] group_valid;

	phy_io_ctrl u_phy_io_ctrl (
		.pll_afi_clk          (pll_afi_clk),
		.reset_n_afi_clk      (reset_n_afi_clk),
		.phy_reset_mem_stable (phy_reset_mem_stable),
		.seq_read_fifo_reset  (seq_read_fifo_reset),
		.afi_rdata_en_full    (afi_rdata_en_full),
		.group_valid          (group_valid),
		.rd_en_shifted        (rd_en_shifted),
		.rd_fifo_clear        (rd_fifo_clear),
		.afi_rdata_valid      (afi_rdata_valid)
	);

	phy_c2p_reg #(.payload_t(afi_data_t)) u_c2p_dq (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               (phy_ddio_dq),
		.q               (c2p_dq)
	);

	phy_c2p_reg #(.payload_t(afi_mask_t)) u_c2p_mask (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               (phy_ddio_wrdata_mask),
		.q               (c2p_mask)
	);

	// The three per-slot enable buses share one register stage
	phy_c2p_reg #(.payload_t(logic [3*`PHY_AFI_DQS_WIDTH-1:0])) u_c2p_strobe (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               ({phy_ddio_oct_ena, phy_ddio_dqs_en, phy_ddio_wrdata_en}),
		.q               ({c2p_oct_ena, c2p_dqs_en, c2p_wrdata_en})
	);

	for (genvar g = 0; g < `PHY_NUM_GROUPS; g++) begin : g_group
		phy_wr_lane #(.GROUP(g)) u_wr_lane (
			.c2p_dq        (c2p_dq),
			.c2p_mask      (c2p_mask),
			.c2p_wrdata_en (c2p_wrdata_en),
			.c2p_dqs_en    (c2p_dqs_en),
			.c2p_oct_ena   (c2p_oct_ena),
			.lane_dq       (mem_wr_dq[g*LANE_DQ_W +: LANE_DQ_W]),
			.lane_dm       (mem_wr_dm[g*LANE_DM_W +: LANE_DM_W]),
			.lane_oe       (mem_wr_oe[g*LANE_DQ_W +: LANE_DQ_W]),
			.lane_dqs_en   (mem_dqs_en[g*LANE_EN_W +: LANE_EN_W]),
			.lane_oct_ena  (mem_oct_ena[g*LANE_EN_W +: LANE_EN_W])
		);

		phy_rd_lat_line u_rd_lat_line (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.rd_en_shifted   (rd_en_shifted),
			.rd_latency      (seq_read_latency_counter),
			.group_valid     (group_valid[g])
		);

		phy_rd_fifo #(.word_t(group_ddr_dq_t)) u_rd_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.rd_fifo_clear   (rd_fifo_clear),
			.push            (mem_rd_strobe[g]),
			.push_word       (mem_rd_dq[g*LANE_DQ_W +: LANE_DQ_W]),
			.pop             (group_valid[g]),
			.pop_word        (ddio_phy_dq[g*LANE_DQ_W +: LANE_DQ_W])
		);
	end

endmodule

// File: tb_phy_io_pads.sv
/*
 Testbench for the PHY I/O pad model. Concurrent assertions compare the DUT
 with a reference model built from the slicing and read latency rules.
 The read latency is only changed while no read is in flight.
*/
`timescale 1ns/1ns

`include "phy_io_macros.svh"

module tb_phy_io_pads
	import phy_io_pkg::*;
();

	localparam int GROUPS = `PHY_NUM_GROUPS;
	localparam int SLOTS = `PHY_RATE_SLOTS;
	localparam int DQ_W = `PHY_GROUP_DQ_WIDTH;
	localparam int LANE_W = SLOTS * DQ_W;
	localparam int STROBE_W = `PHY_AFI_DQS_WIDTH;
	localparam int DRIVE_DLY = 2;
	localparam int READ_WORDS = 6;
	localparam int DRAIN = `PHY_RD_LAT_MAX + 3;
	localparam int CYCLE_LIMIT = 6 + 42 + 3 * (2 + DRAIN + `PHY_RD_LAT_MAX)
		+ (READ_WORDS * 6 + DRAIN) + (10 + DRAIN) + 64;

	logic pll_afi_clk = 1'b0;
	logic reset_n_afi_clk;
	logic phy_reset_mem_stable;
	logic seq_read_fifo_reset;
	rd_lat_t seq_read_latency_counter;
	logic afi_rdata_en_full;
	afi_data_t phy_ddio_dq;
	afi_strobe_t phy_ddio_wrdata_en;
	afi_mask_t phy_ddio_wrdata_mask;
	afi_strobe_t phy_ddio_dqs_en;
	afi_strobe_t phy_ddio_oct_ena;
	logic [`PHY_AFI_DATA_WIDTH-1:0] mem_rd_dq;
	logic [GROUPS-1:0] mem_rd_strobe;

	wire [`PHY_AFI_DATA_WIDTH-1:0] mem_wr_dq;
	wire [`PHY_AFI_MASK_WIDTH-1:0] mem_wr_dm;
	wire [STROBE_W*DQ_W-1:0] mem_wr_oe;
	wire [STROBE_W-1:0] mem_dqs_en;
	wire [STROBE_W-1:0] mem_oct_ena;
	wire [`PHY_AFI_DATA_WIDTH-1:0] ddio_phy_dq;
	wire [SLOTS-1:0] afi_rdata_valid;

	logic [`PHY_AFI_DATA_WIDTH-1:0] exp_wr_dq;
	logic [`PHY_AFI_MASK_WIDTH-1:0] exp_wr_dm;
	logic [STROBE_W*DQ_W-1:0] exp_wr_oe;
	logic [STROBE_W-1:0] exp_dqs_en;
	logic [STROBE_W-1:0] exp_oct_ena;
	logic [`PHY_AFI_DATA_WIDTH-1:0] exp_rd_dq;
	logic [SLOTS-1:0] exp_valid;

	logic [31:0] lcg_state = 32'hb82a_5f4a;
	int err_count = 0;
	int test_count = 0;
	int test_err_base = 0;
	int words_read = 0;
	int cycle_count = 0;
	int due_q[$];
	group_ddr_dq_t word_q[GROUPS][$];

	phy_io_pads u_phy_io_pads (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.phy_reset_mem_stable     (phy_reset_mem_stable),
		.seq_read_fifo_reset      (seq_read_fifo_reset),
		.seq_read_latency_counter (seq_read_latency_counter),
		.afi_rdata_en_full        (afi_rdata_en_full),
		.phy_ddio_dq              (phy_ddio_dq),
		.phy_ddio_wrdata_en       (phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask     (phy_ddio_wrdata_mask),
		.phy_ddio_dqs_en          (phy_ddio_dqs_en),
		.phy_ddio_oct_ena         (phy_ddio_oct_ena),
		.mem_rd_dq                (mem_rd_dq),
		.mem_rd_strobe            (mem_rd_strobe),
		.mem_wr_dq                (mem_wr_dq),
		.mem_wr_dm                (mem_wr_dm),
		.mem_wr_oe                (mem_wr_oe),
		.mem_dqs_en               (mem_dqs_en),
		.mem_oct_ena              (mem_oct_ena),
		.ddio_phy_dq              (ddio_phy_dq),
		.afi_rdata_valid          (afi_rdata_valid)
	);

	always #10 pll_afi_clk = ~pll_afi_clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// AFI field s * GROUPS + g goes to slot s of group g on the pad side
	function automatic logic [31:0] remap_fields(input logic [31:0] afi, input int fw);
		logic [31:0] r;
		r = '0;
		for (int g = 0; g < GROUPS; g++) begin
			for (int s = 0; s < SLOTS; s++) begin
				for (int b = 0; b < fw; b++) begin
					r[(g*SLOTS+s)*fw + b] = afi[(s*GROUPS+g)*fw + b];
				end
			end
		end
		return r;
	endfunction

	function automatic logic [31:0] expand_oe(input logic [STROBE_W-1:0] en);
		logic [31:0] r;
		r = '0;
		for (int g = 0; g < GROUPS; g++) begin
			for (int s = 0; s < SLOTS; s++) begin
				for (int b = 0; b < DQ_W; b++) begin
					r[(g*SLOTS+s)*DQ_W + b] = en[s*GROUPS+g];
				end
			end
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		err_count++;
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
	endtask

	// Reference model, reading the inputs as they stood before each edge
	always @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin : ref_model
		logic [31:0] t;
		if (!reset_n_afi_clk) begin
			exp_wr_dq <= '0;
			exp_wr_dm <= '0;
			exp_wr_oe <= '0;
			exp_dqs_en <= '0;
			exp_oct_ena <= '0;
			exp_rd_dq <= '0;
			exp_valid <= '0;
			due_q.delete();
			for (int g = 0; g < GROUPS; g++) begin
				word_q[g].delete();
			end
		end else begin
			exp_wr_dq <= remap_fields(phy_ddio_dq, DQ_W);
			exp_wr_oe <= expand_oe(phy_ddio_wrdata_en);
			t = remap_fields(32'(phy_ddio_wrdata_mask), `PHY_GROUP_DM_WIDTH);
			exp_wr_dm <= t[`PHY_AFI_MASK_WIDTH-1:0];
			t = remap_fields(32'(phy_ddio_dqs_en), 1);
			exp_dqs_en <= t[STROBE_W-1:0];
			t = remap_fields(32'(phy_ddio_oct_ena), 1);
			exp_oct_ena <= t[STROBE_W-1:0];

			// An enable sampled now is due L + 1 edges later
			if (due_q.size() != 0 && due_q[0] == cycle_count) begin
				void'(due_q.pop_front());
				exp_valid <= '1;
				words_read++;
				for (int g = 0; g < GROUPS; g++) begin
					if (word_q[g].size() != 0) begin
						exp_rd_dq[g*LANE_W +: LANE_W] <= word_q[g].pop_front();
					end
				end
			end else begin
				exp_valid <= '0;
			end
			if (afi_rdata_en_full) begin
				due_q.push_back(cycle_count + int'(seq_read_latency_counter) + 1);
			end

			if (!phy_reset_mem_stable || seq_read_fifo_reset) begin
				for (int g = 0; g < GROUPS; g++) begin
					word_q[g].delete();
				end
			end else begin
				for (int g = 0; g < GROUPS; g++) begin
					if (mem_rd_strobe[g]) begin
						word_q[g].push_back(mem_rd_dq[g*LANE_W +: LANE_W]);
					end
				end
			end
		end
	end

	a_wr_dq: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		mem_wr_dq == exp_wr_dq)
		else report_mismatch("mem_wr_dq", 32'($sampled(mem_wr_dq)), 32'($sampled(exp_wr_dq)));
	a_wr_dm: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		mem_wr_dm == exp_wr_dm)
		else report_mismatch("mem_wr_dm", 32'($sampled(mem_wr_dm)), 32'($sampled(exp_wr_dm)));
	a_wr_oe: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		mem_wr_oe == exp_wr_oe)
		else report_mismatch("mem_wr_oe", 32'($sampled(mem_wr_oe)), 32'($sampled(exp_wr_oe)));
	a_dqs_en: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		mem_dqs_en == exp_dqs_en)
		else report_mismatch("mem_dqs_en", 32'($sampled(mem_dqs_en)),
			32'($sampled(exp_dqs_en)));
	a_oct_ena: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		mem_oct_ena == exp_oct_ena)
		else report_mismatch("mem_oct_ena", 32'($sampled(mem_oct_ena)),
			32'($sampled(exp_oct_ena)));
	a_rd_valid: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid == exp_valid)
		else report_mismatch("afi_rdata_valid", 32'($sampled(afi_rdata_valid)),
			32'($sampled(exp_valid)));
	a_rd_dq: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		ddio_phy_dq == exp_rd_dq)
		else report_mismatch("ddio_phy_dq", 32'($sampled(ddio_phy_dq)),
			32'($sampled(exp_rd_dq)));

	always @(posedge pll_afi_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run went past the limit of %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#DRIVE_DLY;
	endtask

	task automatic push_words(input logic [GROUPS-1:0] sel);
		logic [31:0] r;
		for (int g = 0; g < GROUPS; g++) begin
			r = lcg_next();
			mem_rd_dq[g*LANE_W +: LANE_W] = r[LANE_W-1:0];
		end
		mem_rd_strobe = sel;
		next_cycle();
		mem_rd_strobe = '0;
	endtask

	task automatic read_pulses(input int n);
		afi_rdata_en_full = 1'b1;
		repeat (n) next_cycle();
		afi_rdata_en_full = 1'b0;
	endtask

	// One more edge after the last pop lets the assertions see it
	task automatic wait_read_done();
		while (due_q.size() != 0) begin
			next_cycle();
		end
		next_cycle();
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s finished with %0d errors", test_count, name,
			err_count - test_err_base);
		test_err_base = err_count;
	endtask

	initial begin : stimulus
		logic [31:0] r;
		rd_lat_t lat_list [3];
		lat_list = '{5'd1, 5'd5, 5'd31};
		reset_n_afi_clk = 1'b0;
		phy_reset_mem_stable = 1'b1;
		seq_read_fifo_reset = 1'b0;
		seq_read_latency_counter = 5'd5;
		afi_rdata_en_full = 1'b0;
		phy_ddio_dq = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_dqs_en = '0;
		phy_ddio_oct_ena = '0;
		mem_rd_dq = '0;
		mem_rd_strobe = '0;
		repeat (2) @(posedge pll_afi_clk);
		#DRIVE_DLY;
		reset_n_afi_clk = 1'b1;

		repeat (3) next_cycle();
		end_test("reset_state");

		repeat (40) begin
			phy_ddio_dq = lcg_next();
			r = lcg_next();
			phy_ddio_wrdata_en = r[3:0];
			phy_ddio_wrdata_mask = r[7:4];
			phy_ddio_dqs_en = r[11:8];
			phy_ddio_oct_ena = r[15:12];
			next_cycle();
		end
		phy_ddio_dq = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_dqs_en = '0;
		phy_ddio_oct_ena = '0;
		next_cycle();
		end_test("write_slicing");

		for (int i = 0; i < 3; i++) begin
			seq_read_latency_counter = lat_list[i];
			push_words('1);
			read_pulses(1);
			wait_read_done();
			// The enable keeps shifting past the tap until it leaves the line
			repeat (`PHY_RD_LAT_MAX) next_cycle();
		end
		end_test("read_latency");

		// Groups sometimes receive their word in different cycles
		seq_read_latency_counter = 5'd7;
		for (int i = 0; i < READ_WORDS; i++) begin
			r = lcg_next();
			repeat (r[1:0]) next_cycle();
			if (r[4]) begin
				push_words('1);
			end else begin
				push_words(2'b01);
				push_words(2'b10);
			end
		end
		read_pulses(READ_WORDS);
		wait_read_done();
		end_test("read_order");

		repeat (3) push_words('1);
		phy_reset_mem_stable = 1'b0;
		next_cycle();
		phy_reset_mem_stable = 1'b1;
		repeat (3) push_words('1);
		read_pulses(3);
		wait_read_done();
		end_test("fifo_clear");

		$display("tests %0d, words read %0d, errors %0d", test_count, words_read, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: phy_io_pads.f
+incdir+.
phy_io_pkg.sv
phy_c2p_reg.sv
phy_wr_lane.sv
phy_rd_lat_line.sv
phy_rd_fifo.sv
phy_io_ctrl.sv
phy_io_pads.sv
tb_phy_io_pads.sv

// File: Bender.yml
package:
  name: phy_io_pads

export_include_dirs:
  - .

sources:
  - files:
      - phy_io_pkg.sv
      - phy_c2p_reg.sv
      - phy_wr_lane.sv
      - phy_rd_lat_line.sv
      - phy_rd_fifo.sv
      - phy_io_ctrl.sv
      - phy_io_pads.sv
  - target: test
    files:
      - tb_phy_io_pads.sv
